/* logic/busAccessSettings.svh */
// ============================================================
// Width and line-size macros of the bus access unit:
// bus address and data widths, words per cache line
// ============================================================

`ifndef BUS_ACCESS_SETTINGS_SVH
`define BUS_ACCESS_SETTINGS_SVH

// Byte address width of the peripheral bus
`define AddrWidth 32

// Data width of the peripheral bus, one word per access
`define WordWidth 32

// Words moved for one line of each cache
`define DCacheLineWords 4
`define ICacheLineWords 8

`endif

/* logic/cacheRequestPkg.sv */
// ============================================================
// Cache-side types of the bus access unit:
// the transfer operation enum shared by arbiter and datapath
// ============================================================

`default_nettype none

package cacheRequestPkg;

    // The I/O codes are reserved for uncached access, which this unit does not serve
    typedef enum logic [2:0] {
        opIdle        = 3'h0,
        opReserved    = 3'h1,
        opIoRead      = 3'h2,
        opIoWrite     = 3'h3,
        opDCacheRead  = 3'h4,
        opDCacheWrite = 3'h5,
        opICacheRead  = 3'h6,
        opICacheWrite = 3'h7
    } transferOp;

endpackage

`default_nettype wire

/* logic/apbBusPkg.sv */
// ============================================================
// Bus-side types of the bus access unit:
// the phase enum of the two-phase peripheral bus
// ============================================================

`default_nettype none

package apbBusPkg;

    // Setup drives select alone, access adds enable until ready
    typedef enum logic [1:0] {
        phaseIdle   = 2'h0,
        phaseSetup  = 2'h1,
        phaseAccess = 2'h2
    } busPhase;

endpackage

`default_nettype wire

/* logic/requestArbiter.sv */
// ============================================================
// Request arbiter: fixed-priority pick of the next cache
// request, hold of the active operation, grant decode
// ============================================================

`timescale 1ns/10ps
`default_nettype none

module requestArbiter
    import cacheRequestPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dcReadReq,
    input  logic      dcWriteReq,
    input  logic      icReadReq,
    input  logic      icWriteReq,
    input  logic      done,
    output transferOp activeOp,
    output logic      accept,
    output logic      dcReadGrant,
    output logic      dcWriteGrant,
    output logic      icReadGrant,
    output logic      icWriteGrant
);

    transferOp chosenOp;
    logic      anyReq;

    // Write-backs go first so a dirty line leaves before its slot is refilled
    always_comb begin
        anyReq = dcWriteReq || dcReadReq || icWriteReq || icReadReq;
        if (dcWriteReq) begin
            chosenOp = opDCacheWrite;
        end else if (dcReadReq) begin
            chosenOp = opDCacheRead;
        end else if (icWriteReq) begin
            chosenOp = opICacheWrite;
        end else if (icReadReq) begin
            chosenOp = opICacheRead;
        end else begin
            chosenOp = opIdle;
        end
    end

    // Only an idle arbiter takes a new request
    assign accept = (activeOp == opIdle) && anyReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            activeOp <= opIdle;
        end else if (activeOp == opIdle) begin
            activeOp <= chosenOp;
        end else if (done) begin
            activeOp <= opIdle;
        end
    end

    // done lasts one cycle, so each grant is a single pulse
    always_comb begin
        dcReadGrant  = done && (activeOp == opDCacheRead);
        dcWriteGrant = done && (activeOp == opDCacheWrite);
        icReadGrant  = done && (activeOp == opICacheRead);
        icWriteGrant = done && (activeOp == opICacheWrite);
    end

    // The sequencer relies on the operation staying put for the whole line
    assert property (@(posedge clk) disable iff (rst)
        (activeOp != opIdle) && !done |=> $stable(activeOp));

endmodule

`default_nettype wire

/* logic/apbLineSequencer.sv */
// ============================================================
// Line sequencer: bus phase FSM, word index through a line,
// bus address and write data, end-of-line flag
// ============================================================

`timescale 1ns/10ps
`default_nettype none
`include "busAccessSettings.svh"

module apbLineSequencer
    import cacheRequestPkg::*;
    import apbBusPkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  transferOp                           activeOp,
    input  logic [`AddrWidth-1:0]               dcAddr,
    input  logic [`AddrWidth-1:0]               icAddr,
    input  logic [`WordWidth-1:0]               dcWord,
    input  logic [`WordWidth-1:0]               icWord,
    input  logic                                ready,
    output logic [`AddrWidth-1:0]               addr,
    output logic [`WordWidth-1:0]               wdata,
    output logic                                select,
    output logic                                enable,
    output logic                                write,
    output logic [$clog2(`ICacheLineWords)-1:0] wordIndex,
    output logic                                capture,
    output logic                                done
);

    // The instruction line is the longer one and sets the index width
    localparam int IndexWidth = $clog2(`ICacheLineWords);
    localparam int ByteShift  = $clog2(`WordWidth / 8);

    busPhase               phase;
    busPhase               nextPhase;
    logic                  isDcOp;
    logic                  isIcOp;
    logic                  isWriteOp;
    logic                  lastWord;
    logic [`AddrWidth-1:0] lineBase;

    always_comb begin
        isDcOp    = (activeOp == opDCacheRead) || (activeOp == opDCacheWrite);
        isIcOp    = (activeOp == opICacheRead) || (activeOp == opICacheWrite);
        isWriteOp = (activeOp == opDCacheWrite) || (activeOp == opICacheWrite);
        if (isDcOp) begin
            lastWord = (wordIndex == IndexWidth'(`DCacheLineWords - 1));
        end else begin
            lastWord = (wordIndex == IndexWidth'(`ICacheLineWords - 1));
        end
    end

    // Address and data only move when the index steps, which holds them across wait states
    always_comb begin
        if (isDcOp) begin
            lineBase = dcAddr;
            wdata    = dcWord;
        end else if (isIcOp) begin
            lineBase = icAddr;
            wdata    = icWord;
        end else begin
            lineBase = '0;
            wdata    = '0;
        end
        addr = lineBase + (`AddrWidth'(wordIndex) << ByteShift);
    end

    always_comb begin
        select  = (phase != phaseIdle);
        enable  = (phase == phaseAccess);
        write   = enable && isWriteOp;
        capture = enable && ready;
    end

    // Every word passes through idle, setup and access
    always_comb begin
        nextPhase = phaseIdle;
        if ((isDcOp || isIcOp) && !done) begin
            case (phase)
                phaseIdle:   nextPhase = phaseSetup;
                phaseSetup:  nextPhase = phaseAccess;
                phaseAccess: nextPhase = ready ? phaseIdle : phaseAccess;
                default:     nextPhase = phaseIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= phaseIdle;
            wordIndex <= '0;
            done      <= 1'b0;
        end else begin
            phase <= nextPhase;
            done  <= capture && lastWord;
            if (!(isDcOp || isIcOp)) begin
                wordIndex <= '0;
            end else if (capture) begin
                wordIndex <= lastWord ? '0 : wordIndex + 1'b1;
            end
        end
    end

    // An access cycle is always entered from a setup cycle
    assert property (@(posedge clk) disable iff (rst)
        $rose(enable) |-> select && $past(select && !enable));

    // The slave sees one address from setup until it answers
    assert property (@(posedge clk) disable iff (rst)
        select && !(enable && ready) |=> $stable(addr));

endmodule

`default_nettype wire

/* logic/lineBuffer.sv */
// ============================================================
// Line buffer of one cache: holds the write-back line or
// gathers a fill word by word, and offers the current word
// ============================================================

`timescale 1ns/10ps
`default_nettype none
`include "busAccessSettings.svh"

module lineBuffer
    import cacheRequestPkg::*;
#(
    parameter int wordCount = `DCacheLineWords
)(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                accept,
    input  logic [wordCount-1:0][`WordWidth-1:0] loadValue,
    input  transferOp                           activeOp,
    input  transferOp                           readOp,
    input  transferOp                           writeOp,
    input  logic [$clog2(`ICacheLineWords)-1:0] wordIndex,
    input  logic                                capture,
    input  logic [`WordWidth-1:0]               rdata,
    output logic [wordCount-1:0][`WordWidth-1:0] lineValue,
    output logic [`WordWidth-1:0]               currentWord
);

    localparam int IndexWidth = $clog2(`ICacheLineWords);

    // A fill overwrites every word, so loading on any accept is harmless
    always_ff @(posedge clk) begin
        if (rst) begin
            lineValue <= '0;
        end else if (accept) begin
            lineValue <= loadValue;
        end else if (activeOp == readOp) begin
            for (int i = 0; i < wordCount; i++) begin
                if (capture && (wordIndex == IndexWidth'(i))) begin
                    lineValue[i] <= rdata;
                end
            end
        end else if (activeOp != writeOp) begin
            lineValue <= '0;
        end
    end

    always_comb begin
        currentWord = '0;
        for (int i = 0; i < wordCount; i++) begin
            if (wordIndex == IndexWidth'(i)) begin
                currentWord = lineValue[i];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/busAccessUnit.sv */
// ============================================================
// Bus access unit top: arbiter, line sequencer and one line
// buffer per cache, wired to the cache and bus ports
// ============================================================

`timescale 1ns/10ps
`default_nettype none
`include "busAccessSettings.svh"

module busAccessUnit
    import cacheRequestPkg::*;
(
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       dcReadReq,
    input  logic                                       dcWriteReq,
    input  logic                                       icReadReq,
    input  logic                                       icWriteReq,
    input  logic [`AddrWidth-1:0]                      dcAddr,
    input  logic [`AddrWidth-1:0]                      icAddr,
    input  logic [`DCacheLineWords-1:0][`WordWidth-1:0] dcWriteValue,
    input  logic [`ICacheLineWords-1:0][`WordWidth-1:0] icWriteValue,
    output logic                                       dcReadGrant,
    output logic                                       dcWriteGrant,
    output logic                                       icReadGrant,
    output logic                                       icWriteGrant,
    output logic [`DCacheLineWords-1:0][`WordWidth-1:0] dcReadValue,
    output logic [`ICacheLineWords-1:0][`WordWidth-1:0] icReadValue,
    output logic [`AddrWidth-1:0]                      addr,
    output logic                                       select,
    output logic                                       enable,
    output logic                                       write,
    output logic [`WordWidth-1:0]                      wdata,
    input  logic [`WordWidth-1:0]                      rdata,
    input  logic                                       ready
);

    transferOp                           activeOp;
    logic                                accept;
    logic                                done;
    logic                                capture;
    logic [$clog2(`ICacheLineWords)-1:0] wordIndex;
    logic [`WordWidth-1:0]               dcWord;
    logic [`WordWidth-1:0]               icWord;

    requestArbiter arbiter (
        .clk(clk), .rst(rst),
        .dcReadReq(dcReadReq), .dcWriteReq(dcWriteReq),
        .icReadReq(icReadReq), .icWriteReq(icWriteReq),
        .done(done), .activeOp(activeOp), .accept(accept),
        .dcReadGrant(dcReadGrant), .dcWriteGrant(dcWriteGrant),
        .icReadGrant(icReadGrant), .icWriteGrant(icWriteGrant)
    );

    apbLineSequencer sequencer (
        .clk(clk), .rst(rst), .activeOp(activeOp),
        .dcAddr(dcAddr), .icAddr(icAddr), .dcWord(dcWord), .icWord(icWord),
        .ready(ready), .addr(addr), .wdata(wdata),
        .select(select), .enable(enable), .write(write),
        .wordIndex(wordIndex), .capture(capture), .done(done)
    );

    // Each buffer answers only to its own cache's pair of operations
    lineBuffer #(.wordCount(`DCacheLineWords)) dcBuffer (
        .clk(clk), .rst(rst), .accept(accept), .loadValue(dcWriteValue),
        .activeOp(activeOp), .readOp(opDCacheRead), .writeOp(opDCacheWrite),
        .wordIndex(wordIndex), .capture(capture), .rdata(rdata),
        .lineValue(dcReadValue), .currentWord(dcWord)
    );

    lineBuffer #(.wordCount(`ICacheLineWords)) icBuffer (
        .clk(clk), .rst(rst), .accept(accept), .loadValue(icWriteValue),
        .activeOp(activeOp), .readOp(opICacheRead), .writeOp(opICacheWrite),
        .wordIndex(wordIndex), .capture(capture), .rdata(rdata),
        .lineValue(icReadValue), .currentWord(icWord)
    );

endmodule

`default_nettype wire

/* test/busAccessUnitTb.sv */
// ============================================================
// Testbench of the bus access unit: bus slave memory model
// with random wait states, protocol monitor, directed tests,
// compare tasks and a watchdog
// ============================================================

`timescale 1ns/10ps
`default_nettype none
`include "busAccessSettings.svh"

module busAccessUnitTb
    import cacheRequestPkg::*;
    import apbBusPkg::*;
;

    localparam int ClkPeriod     = 4;
    localparam int MemWords      = 256;
    // Worst word is idle, setup and four access cycles, plus arbitration
    localparam int MaxLineCycles = `ICacheLineWords * 6 + 4;
    localparam int NumTransfers  = 8;
    localparam int TimeoutNs     = (NumTransfers * MaxLineCycles + 60) * ClkPeriod * 2;

    typedef logic [`ICacheLineWords-1:0][`WordWidth-1:0] wideLine;
    typedef logic [`DCacheLineWords-1:0][`WordWidth-1:0] dcLine;

    logic                  clk;
    logic                  rst;
    logic                  dcReadReq;
    logic                  dcWriteReq;
    logic                  icReadReq;
    logic                  icWriteReq;
    logic [`AddrWidth-1:0] dcAddr;
    logic [`AddrWidth-1:0] icAddr;
    dcLine                 dcWriteValue;
    wideLine               icWriteValue;
    logic                  dcReadGrant;
    logic                  dcWriteGrant;
    logic                  icReadGrant;
    logic                  icWriteGrant;
    dcLine                 dcReadValue;
    wideLine               icReadValue;
    logic [`AddrWidth-1:0] addr;
    logic                  select;
    logic                  enable;
    logic                  write;
    logic [`WordWidth-1:0] wdata;
    logic [`WordWidth-1:0] rdata;
    logic                  ready;

    logic [`WordWidth-1:0] mem [MemWords];
    logic [`AddrWidth-1:0] logAddr [$];
    logic [`WordWidth-1:0] logData [$];
    logic                  logWrite [$];
    logic [31:0]           lfsrState;
    int                    errorCount;
    dcLine                 grantDcLine;
    wideLine               grantIcLine;

    busAccessUnit u_dut (
        .clk(clk), .rst(rst),
        .dcReadReq(dcReadReq), .dcWriteReq(dcWriteReq),
        .icReadReq(icReadReq), .icWriteReq(icWriteReq),
        .dcAddr(dcAddr), .icAddr(icAddr),
        .dcWriteValue(dcWriteValue), .icWriteValue(icWriteValue),
        .dcReadGrant(dcReadGrant), .dcWriteGrant(dcWriteGrant),
        .icReadGrant(icReadGrant), .icWriteGrant(icWriteGrant),
        .dcReadValue(dcReadValue), .icReadValue(icReadValue),
        .addr(addr), .select(select), .enable(enable), .write(write),
        .wdata(wdata), .rdata(rdata), .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(TimeoutNs);
        $display("Timeout: the tests did not finish within %0d ns", TimeoutNs);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic drawBit(output logic bitValue);
        lfsrState = lfsrNext(lfsrState);
        bitValue  = lfsrState[0];
    endtask

    function automatic int memIndex(input logic [`AddrWidth-1:0] byteAddr);
        return int'(byteAddr[9:2]);
    endfunction

    // Power-up contents of the slave, different for every word address
    function automatic logic [`WordWidth-1:0] fillWord(input int index);
        logic [7:0] low;
        low = index[7:0];
        return {8'hA5, low, ~low, low ^ 8'h5A};
    endfunction

    function automatic transferOp grantKind();
        int hot;
        hot = int'(dcReadGrant) + int'(dcWriteGrant) + int'(icReadGrant) + int'(icWriteGrant);
        if (hot > 1) return opReserved;
        if (dcWriteGrant) return opDCacheWrite;
        if (dcReadGrant) return opDCacheRead;
        if (icWriteGrant) return opICacheWrite;
        if (icReadGrant) return opICacheRead;
        return opIdle;
    endfunction

    task automatic stopOnError(input string what);
        errorCount++;
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkBit(input string name, input logic expValue, input logic gotValue);
        if (gotValue !== expValue) begin
            stopOnError($sformatf("Fail %s expected %h got %h", name, expValue, gotValue));
        end
    endtask

    task automatic checkOp(input string name, input transferOp expOp, input transferOp gotOp);
        if (gotOp !== expOp) begin
            stopOnError($sformatf("Fail %s expected %h got %h", name, expOp, gotOp));
        end
    endtask

    task automatic checkPhase(input string name, input busPhase expPhase, input busPhase gotPhase);
        if (gotPhase !== expPhase) begin
            stopOnError($sformatf("Fail %s expected %h got %h", name, expPhase, gotPhase));
        end
    endtask

    task automatic checkAccess(input string name, input logic [`AddrWidth-1:0] expAddr,
                               input logic [`WordWidth-1:0] expData,
                               input logic [`AddrWidth-1:0] gotAddr,
                               input logic [`WordWidth-1:0] gotData);
        if (gotAddr !== expAddr) begin
            stopOnError($sformatf("Fail %s addr expected %h got %h", name, expAddr, gotAddr));
        end
        if (gotData !== expData) begin
            stopOnError($sformatf("Fail %s data expected %h got %h", name, expData, gotData));
        end
    endtask

    task automatic checkLine(input string name, input int count, input wideLine expLine,
                             input wideLine gotLine);
        for (int i = 0; i < count; i++) begin
            if (gotLine[i] !== expLine[i]) begin
                stopOnError($sformatf("Fail %s word %0d expected %h got %h",
                                      name, i, expLine[i], gotLine[i]));
            end
        end
    endtask

    // Compares a run of logged bus accesses with words at rising addresses
    task automatic checkLog(input int first, input logic [`AddrWidth-1:0] base, input int count,
                            input logic isWrite, input wideLine expData);
        if (logAddr.size() < first + count) begin
            stopOnError($sformatf("Only %0d bus accesses were seen, %0d expected",
                                  logAddr.size(), first + count));
        end
        for (int i = 0; i < count; i++) begin
            checkAccess("bus access", base + 32'(i * 4), expData[i],
                        logAddr[first + i], logData[first + i]);
            checkBit("write", isWrite, logWrite[first + i]);
        end
    endtask

    // Once a write-back is granted the cache may change its write line, so a
    // later fill of the same cache can only return words it gathered from the bus
    task automatic dropRequest(input transferOp op);
        case (op)
            opDCacheWrite: begin
                dcWriteReq   <= 1'b0;
                dcWriteValue <= ~dcWriteValue;
            end
            opDCacheRead:  dcReadReq <= 1'b0;
            opICacheWrite: begin
                icWriteReq   <= 1'b0;
                icWriteValue <= ~icWriteValue;
            end
            opICacheRead:  icReadReq <= 1'b0;
            default:       ;
        endcase
    endtask

    // Waits for a grant, keeps the read lines it came with and releases the request
    task automatic waitForGrant(input transferOp expOp);
        int        cycles;
        transferOp gotOp;
        cycles = 0;
        gotOp  = opIdle;
        while (gotOp == opIdle) begin
            @(negedge clk);
            gotOp = grantKind();
            cycles++;
            if (cycles > MaxLineCycles * 2) begin
                stopOnError($sformatf("No grant came within %0d cycles", cycles));
            end
        end
        checkOp("grant kind", expOp, gotOp);
        grantDcLine = dcReadValue;
        grantIcLine = icReadValue;
        @(posedge clk);
        dropRequest(gotOp);
        @(negedge clk);
        checkOp("grant after its pulse", opIdle, grantKind());
    endtask

    task automatic clearLog();
        logAddr.delete();
        logData.delete();
        logWrite.delete();
    endtask

    task automatic testIdleAfterReset();
        repeat (10) begin
            @(negedge clk);
            checkBit("select", 1'b0, select);
            checkBit("enable", 1'b0, enable);
            checkBit("write", 1'b0, write);
            checkOp("grant kind", opIdle, grantKind());
            checkOp("activeOp", opIdle, u_dut.arbiter.activeOp);
            checkPhase("phase", phaseIdle, u_dut.sequencer.phase);
        end
    endtask

    task automatic testDcWriteBack();
        dcLine line;
        for (int i = 0; i < `DCacheLineWords; i++) begin
            line[i] = 32'h1357_0000 + 32'(i * 32'h0011);
        end
        clearLog();
        @(posedge clk);
        dcAddr       <= 32'h0000_0040;
        dcWriteValue <= line;
        dcWriteReq   <= 1'b1;
        waitForGrant(opDCacheWrite);
        checkLog(0, 32'h0000_0040, `DCacheLineWords, 1'b1, wideLine'(line));
        if (logAddr.size() != `DCacheLineWords) begin
            stopOnError("The data write-back made the wrong number of bus accesses");
        end
    endtask

    task automatic testDcFillWithWaits();
        wideLine expLine;
        expLine = '0;
        for (int i = 0; i < `DCacheLineWords; i++) begin
            expLine[i] = fillWord(memIndex(32'h0000_0080) + i);
        end
        clearLog();
        @(posedge clk);
        dcAddr    <= 32'h0000_0080;
        dcReadReq <= 1'b1;
        waitForGrant(opDCacheRead);
        checkLine("dcReadValue", `DCacheLineWords, expLine, wideLine'(grantDcLine));
        checkLog(0, 32'h0000_0080, `DCacheLineWords, 1'b0, expLine);
    endtask

    task automatic testIcWriteThenFill();
        wideLine line;
        for (int i = 0; i < `ICacheLineWords; i++) begin
            line[i] = 32'hC0DE_0100 ^ 32'(i * 32'h0101_0101);
        end
        clearLog();
        @(posedge clk);
        icAddr       <= 32'h0000_0100;
        icWriteValue <= line;
        icWriteReq   <= 1'b1;
        waitForGrant(opICacheWrite);
        checkLog(0, 32'h0000_0100, `ICacheLineWords, 1'b1, line);
        @(posedge clk);
        icReadReq <= 1'b1;
        waitForGrant(opICacheRead);
        checkLine("icReadValue", `ICacheLineWords, line, grantIcLine);
        checkLog(`ICacheLineWords, 32'h0000_0100, `ICacheLineWords, 1'b0, line);
    endtask

    // All four requests at once must be served one by one in fixed priority
    task automatic testPriorityOrder();
        dcLine   dcLineValue;
        wideLine icLineValue;
        for (int i = 0; i < `ICacheLineWords; i++) begin
            icLineValue[i] = 32'h7E57_0000 + 32'(i * 32'h0203);
        end
        for (int i = 0; i < `DCacheLineWords; i++) begin
            dcLineValue[i] = 32'h0BAD_F000 - 32'(i * 32'h0107);
        end
        clearLog();
        @(posedge clk);
        dcAddr       <= 32'h0000_00C0;
        icAddr       <= 32'h0000_0200;
        dcWriteValue <= dcLineValue;
        icWriteValue <= icLineValue;
        dcWriteReq   <= 1'b1;
        dcReadReq    <= 1'b1;
        icWriteReq   <= 1'b1;
        icReadReq    <= 1'b1;
        waitForGrant(opDCacheWrite);
        waitForGrant(opDCacheRead);
        checkLine("dcReadValue", `DCacheLineWords, wideLine'(dcLineValue),
                  wideLine'(grantDcLine));
        waitForGrant(opICacheWrite);
        waitForGrant(opICacheRead);
        checkLine("icReadValue", `ICacheLineWords, icLineValue, grantIcLine);
        checkLog(0, 32'h0000_00C0, `DCacheLineWords, 1'b1, wideLine'(dcLineValue));
        checkLog(4, 32'h0000_00C0, `DCacheLineWords, 1'b0, wideLine'(dcLineValue));
        checkLog(8, 32'h0000_0200, `ICacheLineWords, 1'b1, icLineValue);
        checkLog(16, 32'h0000_0200, `ICacheLineWords, 1'b0, icLineValue);
        if (logAddr.size() != 2 * (`DCacheLineWords + `ICacheLineWords)) begin
            stopOnError("The priority run made the wrong number of bus accesses");
        end
    endtask

    // Slave memory and protocol monitor: looks at the bus on the falling edge
    // and answers with ready and rdata on the next rising edge
    initial begin : slaveModel
        int unsigned           waitLeft;
        logic [1:0]            waitBits;
        logic                  nextReady;
        logic [`WordWidth-1:0] nextRdata;
        logic                  prevSelect;
        logic                  prevEnable;
        logic                  prevReady;
        logic [`AddrWidth-1:0] prevAddr;
        logic [`WordWidth-1:0] prevWdata;
        ready      = 1'b0;
        rdata      = '0;
        waitLeft   = 0;
        prevSelect = 1'b0;
        prevEnable = 1'b0;
        prevReady  = 1'b0;
        prevAddr   = '0;
        prevWdata  = '0;
        forever begin
            @(negedge clk);
            nextReady = 1'b0;
            nextRdata = '0;
            if (!rst) begin
                if (enable && !select) stopOnError("enable is high without select");
                if (write && !enable) stopOnError("write is high outside an access cycle");
                if (enable && !prevEnable && !prevSelect) begin
                    stopOnError("enable rose without a setup cycle before it");
                end
                if (prevSelect && !(prevEnable && prevReady)) begin
                    checkBit("enable", 1'b1, enable);
                    checkAccess("held bus", prevAddr, prevWdata, addr, wdata);
                end
                if (select && addr[`AddrWidth-1:10] != '0) begin
                    stopOnError("The bus address lies outside the slave memory");
                end
                if (select && !enable) begin
                    drawBit(waitBits[0]);
                    drawBit(waitBits[1]);
                    waitLeft  = waitBits;
                    nextReady = (waitLeft == 0);
                end else if (enable && !ready) begin
                    waitLeft  = waitLeft - 1;
                    nextReady = (waitLeft == 0);
                end else if (enable && ready) begin
                    logAddr.push_back(addr);
                    logData.push_back(write ? wdata : rdata);
                    logWrite.push_back(write);
                    if (write) mem[memIndex(addr)] = wdata;
                end
                if (nextReady) nextRdata = mem[memIndex(addr)];
            end
            prevSelect = select && !rst;
            prevEnable = enable && !rst;
            prevReady  = ready;
            prevAddr   = addr;
            prevWdata  = wdata;
            @(posedge clk);
            ready <= nextReady;
            rdata <= nextRdata;
        end
    end

    initial begin
        rst          = 1'b1;
        dcReadReq    = 1'b0;
        dcWriteReq   = 1'b0;
        icReadReq    = 1'b0;
        icWriteReq   = 1'b0;
        dcAddr       = '0;
        icAddr       = '0;
        dcWriteValue = '0;
        icWriteValue = '0;
        lfsrState    = 32'h57eda065;
        errorCount   = 0;
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = fillWord(i);
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        testIdleAfterReset();
        testDcWriteBack();
        testDcFillWithWaits();
        testIcWriteThenFill();
        testPriorityOrder();
        repeat (4) @(posedge clk);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* busAccessUnit.f */
+incdir+logic
logic/cacheRequestPkg.sv
logic/apbBusPkg.sv
logic/requestArbiter.sv
logic/apbLineSequencer.sv
logic/lineBuffer.sv
logic/busAccessUnit.sv
test/busAccessUnitTb.sv

/* Bender.yml */
package:
  name: busAccessUnit

sources:
  - include_dirs:
      - logic
    files:
      - logic/cacheRequestPkg.sv
      - logic/apbBusPkg.sv
      - logic/requestArbiter.sv
      - logic/apbLineSequencer.sv
      - logic/lineBuffer.sv
      - logic/busAccessUnit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/busAccessUnitTb.sv
